// ==== cpuPkg.sv ====
package cpuPkg;

    localparam int WORD_WIDTH      = 32;
    localparam int REG_INDEX_WIDTH = 4;
    localparam int OP_WIDTH        = 4;
    localparam int SHIFT_WIDTH     = $clog2(WORD_WIDTH);  // Shift amount bits in range

    localparam logic [REG_INDEX_WIDTH-1:0] REG_ZERO = 4'd0;   // Always reads zero
    localparam logic [REG_INDEX_WIDTH-1:0] REG_PC   = 4'd15;  // Program counter alias

    localparam logic [WORD_WIDTH-1:0] RESET_VECTOR = 32'h0000_0000;

    // Sequencer ring, one hot
    localparam logic [2:0] PHASE_DECODE  = 3'b001;
    localparam logic [2:0] PHASE_EXECUTE = 3'b010;
    localparam logic [2:0] PHASE_WRITE   = 3'b100;

    localparam logic [OP_WIDTH-1:0] OP_OR   = 4'd0;
    localparam logic [OP_WIDTH-1:0] OP_AND  = 4'd1;
    localparam logic [OP_WIDTH-1:0] OP_ADD  = 4'd2;
    localparam logic [OP_WIDTH-1:0] OP_MUL  = 4'd3;   // Code 4 reserved
    localparam logic [OP_WIDTH-1:0] OP_SHL  = 4'd5;
    localparam logic [OP_WIDTH-1:0] OP_LT   = 4'd6;
    localparam logic [OP_WIDTH-1:0] OP_EQ   = 4'd7;
    localparam logic [OP_WIDTH-1:0] OP_GT   = 4'd8;
    localparam logic [OP_WIDTH-1:0] OP_ANDN = 4'd9;
    localparam logic [OP_WIDTH-1:0] OP_XOR  = 4'd10;
    localparam logic [OP_WIDTH-1:0] OP_SUB  = 4'd11;
    localparam logic [OP_WIDTH-1:0] OP_XNOR = 4'd12;
    localparam logic [OP_WIDTH-1:0] OP_SHR  = 4'd13;
    localparam logic [OP_WIDTH-1:0] OP_NE   = 4'd14;  // Code 15 reserved

    typedef struct packed {
        logic                       immType;   // Operands (X, imm) plus Y
        logic                       storing;
        logic                       derefRhs;  // Memory access at rhs address
        logic [REG_INDEX_WIDTH-1:0] z;
        logic [REG_INDEX_WIDTH-1:0] x;
        logic [REG_INDEX_WIDTH-1:0] y;
        logic [OP_WIDTH-1:0]        op;
        logic [WORD_WIDTH-1:0]      imm;       // Sign extended
        logic                       illegal;
        logic                       branch;    // Writes register 15
    } decodedInsn_t;

endpackage

// ==== regFile.sv ====
`timescale 1ns/1ps

module regFile (
    input  logic                                clk,
    input  logic                                reset_n,
    input  logic                                writeEnable,
    input  logic [cpuPkg::REG_INDEX_WIDTH-1:0]  indexZ,
    input  logic [cpuPkg::REG_INDEX_WIDTH-1:0]  indexX,
    input  logic [cpuPkg::REG_INDEX_WIDTH-1:0]  indexY,
    input  logic [cpuPkg::WORD_WIDTH-1:0]       writeData,
    input  logic [cpuPkg::WORD_WIDTH-1:0]       pc,
    output logic [cpuPkg::WORD_WIDTH-1:0]       valueZ,
    output logic [cpuPkg::WORD_WIDTH-1:0]       valueX,
    output logic [cpuPkg::WORD_WIDTH-1:0]       valueY
);

    logic [cpuPkg::WORD_WIDTH-1:0] regs [1:14];  // General registers only
    logic [cpuPkg::WORD_WIDTH-1:0] pcPlusOne;
    logic                          zWritable;

    assign pcPlusOne = pc + 1'b1;
    assign zWritable = (indexZ != cpuPkg::REG_ZERO) && (indexZ != cpuPkg::REG_PC);

    assign valueZ = (indexZ == cpuPkg::REG_ZERO) ? '0 :
                    (indexZ == cpuPkg::REG_PC)   ? pcPlusOne : regs[indexZ];
    assign valueX = (indexX == cpuPkg::REG_ZERO) ? '0 :
                    (indexX == cpuPkg::REG_PC)   ? pcPlusOne : regs[indexX];
    assign valueY = (indexY == cpuPkg::REG_ZERO) ? '0 :
                    (indexY == cpuPkg::REG_PC)   ? pcPlusOne : regs[indexY];

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            for (int i = 1; i <= 14; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEnable && zWritable) begin
            regs[indexZ] <= writeData;  // Pc writes handled by the core
        end
    end

endmodule

// ==== insnDecoder.sv ====
`timescale 1ns/1ps

module insnDecoder (
    input  logic [cpuPkg::WORD_WIDTH-1:0] insn,
    output cpuPkg::decodedInsn_t          decoded
);

    logic [11:0] immField;

    assign immField = insn[11:0];

    always_comb begin
        decoded.immType  = insn[30];
        decoded.storing  = insn[29];
        decoded.derefRhs = insn[28];
        decoded.z        = insn[27:24];
        decoded.x        = insn[23:20];
        decoded.y        = insn[19:16];
        decoded.op       = insn[15:12];
        decoded.imm      = {{(cpuPkg::WORD_WIDTH-12){immField[11]}}, immField};

        // All ones word stops the core
        decoded.illegal  = &insn;
        decoded.branch   = (insn[27:24] == cpuPkg::REG_PC) && !insn[29];
    end

endmodule

// ==== aluExec.sv ====
`timescale 1ns/1ps

module aluExec (
    input  logic                          clk,
    input  logic                          reset_n,
    input  logic                          enable,
    input  cpuPkg::decodedInsn_t          decoded,
    input  logic [cpuPkg::WORD_WIDTH-1:0] valueX,
    input  logic [cpuPkg::WORD_WIDTH-1:0] valueY,
    output logic [cpuPkg::WORD_WIDTH-1:0] rhs
);

    logic [cpuPkg::WORD_WIDTH-1:0] operandB;
    logic [cpuPkg::WORD_WIDTH-1:0] addend;
    logic [cpuPkg::WORD_WIDTH-1:0] opResult;
    logic                          shiftInRange;

    assign operandB     = decoded.immType ? decoded.imm : valueY;
    assign addend       = decoded.immType ? valueY : decoded.imm;  // Leftover operand
    assign shiftInRange = operandB < cpuPkg::WORD_WIDTH;

    always_comb begin
        unique case (decoded.op)
            cpuPkg::OP_OR:   opResult = valueX | operandB;
            cpuPkg::OP_AND:  opResult = valueX & operandB;
            cpuPkg::OP_ADD:  opResult = valueX + operandB;
            cpuPkg::OP_MUL:  opResult = valueX * operandB;  // Low word only
            cpuPkg::OP_SHL:  opResult = shiftInRange ?
                                 valueX << operandB[cpuPkg::SHIFT_WIDTH-1:0] : '0;
            cpuPkg::OP_LT:   opResult = {cpuPkg::WORD_WIDTH{$signed(valueX) < $signed(operandB)}};
            cpuPkg::OP_EQ:   opResult = {cpuPkg::WORD_WIDTH{valueX == operandB}};
            cpuPkg::OP_GT:   opResult = {cpuPkg::WORD_WIDTH{$signed(valueX) > $signed(operandB)}};
            cpuPkg::OP_ANDN: opResult = valueX & ~operandB;
            cpuPkg::OP_XOR:  opResult = valueX ^ operandB;
            cpuPkg::OP_SUB:  opResult = valueX - operandB;
            cpuPkg::OP_XNOR: opResult = ~(valueX ^ operandB);
            cpuPkg::OP_SHR:  opResult = shiftInRange ?
                                 valueX >> operandB[cpuPkg::SHIFT_WIDTH-1:0] : '0;
            cpuPkg::OP_NE:   opResult = {cpuPkg::WORD_WIDTH{valueX != operandB}};
            default:         opResult = '0;  // Reserved codes
        endcase
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            rhs <= '0;
        end else if (enable) begin
            rhs <= opResult + addend;
        end
    end

endmodule

// ==== cpuCore.sv ====
`timescale 1ns/1ps

module cpuCore (
    input  logic                          clk,
    input  logic                          reset_n,
    output logic [cpuPkg::WORD_WIDTH-1:0] iAddr,
    input  logic [cpuPkg::WORD_WIDTH-1:0] iData,
    output logic [cpuPkg::WORD_WIDTH-1:0] dAddr,
    output logic [cpuPkg::WORD_WIDTH-1:0] dWriteData,
    output logic                          dWrite,
    input  logic [cpuPkg::WORD_WIDTH-1:0] dReadData,
    output logic                          halt
);

    cpuPkg::decodedInsn_t          decoded;
    logic [cpuPkg::WORD_WIDTH-1:0] valueX;
    logic [cpuPkg::WORD_WIDTH-1:0] valueY;
    logic [cpuPkg::WORD_WIDTH-1:0] valueZ;
    logic [cpuPkg::WORD_WIDTH-1:0] rhs;          // Executer result
    logic [cpuPkg::WORD_WIDTH-1:0] resultValue;
    logic [cpuPkg::WORD_WIDTH-1:0] pc;
    logic [2:0]                    phase;
    logic                          haltFlag;
    logic                          regWrite;
    logic                          aluEnable;

    assign iAddr = pc;
    assign halt  = haltFlag;

    // Load or store address comes from the executer when dereferencing
    assign resultValue = decoded.derefRhs ? dReadData : rhs;
    assign dAddr       = decoded.derefRhs ? rhs : valueZ;
    assign dWriteData  = decoded.derefRhs ? valueZ : rhs;

    assign aluEnable = phase[1];
    assign dWrite    = phase[2] && decoded.storing;
    assign regWrite  = phase[2] && !decoded.storing;

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            phase    <= cpuPkg::PHASE_DECODE;
            pc       <= cpuPkg::RESET_VECTOR;
            haltFlag <= 1'b0;
        end else if (!haltFlag) begin
            unique case (phase)
                cpuPkg::PHASE_DECODE: begin
                    phase <= cpuPkg::PHASE_EXECUTE;
                end
                cpuPkg::PHASE_EXECUTE: begin
                    if (decoded.illegal) begin
                        haltFlag <= 1'b1;                  // Park in decode
                        phase    <= cpuPkg::PHASE_DECODE;
                    end else begin
                        phase <= cpuPkg::PHASE_WRITE;
                    end
                end
                cpuPkg::PHASE_WRITE: begin
                    phase <= cpuPkg::PHASE_DECODE;
                    pc    <= decoded.branch ? resultValue : pc + 1'b1;
                end
                default: begin
                    phase <= cpuPkg::PHASE_DECODE;         // Recover a broken ring
                end
            endcase
        end
    end

    insnDecoder i_insnDecoder (
        .insn    (iData),
        .decoded (decoded)
    );

    regFile i_regFile (
        .clk         (clk),
        .reset_n     (reset_n),
        .writeEnable (regWrite),
        .indexZ      (decoded.z),
        .indexX      (decoded.x),
        .indexY      (decoded.y),
        .writeData   (resultValue),
        .pc          (pc),
        .valueZ      (valueZ),
        .valueX      (valueX),
        .valueY      (valueY)
    );

    aluExec i_aluExec (
        .clk     (clk),
        .reset_n (reset_n),
        .enable  (aluEnable),
        .decoded (decoded),
        .valueX  (valueX),
        .valueY  (valueY),
        .rhs     (rhs)
    );

endmodule

// ==== tbClock.sv ====
`timescale 1ns/1ps

module tbClock (
    input  logic restart,  // Sampled on the rising edge
    output logic clk,
    output logic reset_n
);

    localparam int HALF_PERIOD_NS = 2;  // 4 ns period
    localparam int RESET_CYCLES   = 3;

    int   cyclesLeft;
    logic restartSeen;

    initial begin
        clk        = 1'b0;
        reset_n    = 1'b0;
        cyclesLeft = RESET_CYCLES;
    end

    always #HALF_PERIOD_NS clk = ~clk;

    always @(posedge clk) begin
        restartSeen = restart;
        #1;
        if (restartSeen) begin
            cyclesLeft = RESET_CYCLES;
            reset_n    = 1'b0;
        end else if (cyclesLeft > 0) begin
            cyclesLeft = cyclesLeft - 1;
            if (cyclesLeft == 0) begin
                reset_n = 1'b1;  // Release after the last reset edge
            end
        end
    end

endmodule

// ==== tbCpu.sv ====
`timescale 1ns/1ps

module tbCpu;

    localparam int          NUM_TESTS        = 8;
    localparam int          INSNS_PER_TEST   = 300;
    localparam int          CLK_PERIOD_NS    = 4;
    localparam int          HALT_HOLD_CYCLES = 20;
    localparam int unsigned SEED             = 32'h1aae03ef;
    localparam int          WATCHDOG_NS      = NUM_TESTS * INSNS_PER_TEST * 3 * CLK_PERIOD_NS
                                             + NUM_TESTS * 64 * CLK_PERIOD_NS + 1000;

    logic                          clk;
    logic                          reset_n;
    logic                          restart;
    logic [cpuPkg::WORD_WIDTH-1:0] iAddr;
    logic [cpuPkg::WORD_WIDTH-1:0] iData;
    logic [cpuPkg::WORD_WIDTH-1:0] dAddr;
    logic [cpuPkg::WORD_WIDTH-1:0] dWriteData;
    logic                          dWrite;
    logic [cpuPkg::WORD_WIDTH-1:0] dReadData;
    logic                          halt;

    logic [cpuPkg::WORD_WIDTH-1:0] imem [0:255];
    logic [cpuPkg::WORD_WIDTH-1:0] dmem [0:255];
    logic [cpuPkg::WORD_WIDTH-1:0] modelMem [0:255];
    logic [cpuPkg::WORD_WIDTH-1:0] modelRegs [1:14];
    logic [cpuPkg::WORD_WIDTH-1:0] modelPc;

    int          checkCount;
    int          errorCount;
    int          testErrors;
    int unsigned seedDummy;

    tbClock i_tbClock (
        .restart (restart),
        .clk     (clk),
        .reset_n (reset_n)
    );

    cpuCore i_dut (
        .clk        (clk),
        .reset_n    (reset_n),
        .iAddr      (iAddr),
        .iData      (iData),
        .dAddr      (dAddr),
        .dWriteData (dWriteData),
        .dWrite     (dWrite),
        .dReadData  (dReadData),
        .halt       (halt)
    );

    assign iData     = imem[iAddr[7:0]];  // Combinational reads
    assign dReadData = dmem[dAddr[7:0]];

    always @(posedge clk) begin
        if (dWrite) begin
            dmem[dAddr[7:0]] <= #1 dWriteData;  // Store lands just after the edge
        end
    end

    function automatic logic [31:0] randomInsn();
        logic [3:0]  z;
        logic [3:0]  x;
        logic [3:0]  y;
        logic [3:0]  op;
        logic [11:0] imm;
        logic        immType;
        logic        storing;
        logic        deref;
        if ($urandom % 64 == 0) begin
            return '1;  // Illegal word
        end
        x       = $urandom;
        y       = $urandom;
        op      = $urandom;
        imm     = $urandom;
        immType = $urandom;
        storing = ($urandom % 4 == 0);
        deref   = ($urandom % 3 == 0);
        z       = $urandom;
        if ($urandom % 8 == 0) begin
            z = 4'd15;  // Extra jumps
        end
        return {1'b0, immType, storing, deref, z, x, y, op, imm};
    endfunction

    function automatic logic [31:0] readReg(input logic [3:0] index);
        if (index == 4'd0) begin
            return '0;
        end else if (index == 4'd15) begin
            return modelPc + 1;  // Pc reads one ahead
        end
        return modelRegs[index];
    endfunction

    function automatic logic [31:0] aluModel(input logic [3:0] op, input logic [31:0] a,
                                             input logic [31:0] b);
        case (op)
            cpuPkg::OP_OR:   return a | b;
            cpuPkg::OP_AND:  return a & b;
            cpuPkg::OP_ADD:  return a + b;
            cpuPkg::OP_MUL:  return a * b;
            cpuPkg::OP_SHL:  return (b >= 32) ? 32'd0 : a << b[4:0];
            cpuPkg::OP_LT:   return ($signed(a) < $signed(b)) ? '1 : '0;
            cpuPkg::OP_EQ:   return (a == b) ? '1 : '0;
            cpuPkg::OP_GT:   return ($signed(a) > $signed(b)) ? '1 : '0;
            cpuPkg::OP_ANDN: return a & ~b;
            cpuPkg::OP_XOR:  return a ^ b;
            cpuPkg::OP_SUB:  return a - b;
            cpuPkg::OP_XNOR: return ~(a ^ b);
            cpuPkg::OP_SHR:  return (b >= 32) ? 32'd0 : a >> b[4:0];
            cpuPkg::OP_NE:   return (a != b) ? '1 : '0;
            default:         return '0;  // Codes 4 and 15
        endcase
    endfunction

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        checkCount++;
        assert (actual === expected) else begin
            $display("FAILED %s: got %h, expected %h", name, actual, expected);
            testErrors++;
            errorCount++;
        end
    endtask

    task automatic nextCycle();
        @(posedge clk);
        @(negedge clk);  // Outputs settled mid cycle
    endtask

    task automatic fillMemories();
        for (int i = 0; i < 256; i++) begin
            imem[i]     = randomInsn();
            dmem[i]     = $urandom;
            modelMem[i] = dmem[i];
        end
    endtask

    task automatic startTest();
        wait (!reset_n);
        restart = 1'b0;
        @(posedge clk);
        @(posedge clk);  // Last store before reset has landed
        #1;
        fillMemories();
        wait (reset_n);
        @(negedge clk);
    endtask

    task automatic runProgram(input int testIndex);
        logic [31:0] insn;
        logic [31:0] immExt;
        logic [31:0] vx;
        logic [31:0] vy;
        logic [31:0] vz;
        logic [31:0] rhsVal;
        logic [31:0] memAddr;
        logic [31:0] storeData;
        logic [31:0] result;
        int          executed;
        int          stores;
        bit          halted;
        executed   = 0;
        stores     = 0;
        halted     = 1'b0;
        testErrors = 0;
        modelPc    = cpuPkg::RESET_VECTOR;
        for (int r = 1; r <= 14; r++) begin
            modelRegs[r] = '0;
        end
        checkValue("iAddr", iAddr, cpuPkg::RESET_VECTOR);
        checkValue("halt", halt, 1'b0);
        checkValue("dWrite", dWrite, 1'b0);
        while (executed < INSNS_PER_TEST && !halted && testErrors == 0) begin
            checkValue("iAddr", iAddr, modelPc);  // Decode phase
            checkValue("halt", halt, 1'b0);
            checkValue("dWrite", dWrite, 1'b0);
            insn = imem[modelPc[7:0]];
            nextCycle();
            checkValue("halt", halt, 1'b0);
            checkValue("dWrite", dWrite, 1'b0);
            if (insn == '1) begin
                for (int c = 0; c < HALT_HOLD_CYCLES; c++) begin
                    nextCycle();
                    checkValue("halt", halt, 1'b1);
                    checkValue("iAddr", iAddr, modelPc);
                    checkValue("dWrite", dWrite, 1'b0);
                end
                halted = 1'b1;
            end else begin
                immExt = {{20{insn[11]}}, insn[11:0]};
                vx     = readReg(insn[23:20]);
                vy     = readReg(insn[19:16]);
                vz     = readReg(insn[27:24]);
                if (insn[30]) begin
                    rhsVal = aluModel(insn[15:12], vx, immExt) + vy;
                end else begin
                    rhsVal = aluModel(insn[15:12], vx, vy) + immExt;
                end
                memAddr   = insn[28] ? rhsVal : vz;
                storeData = insn[28] ? vz : rhsVal;
                result    = insn[28] ? modelMem[memAddr[7:0]] : rhsVal;
                nextCycle();  // Write phase
                checkValue("halt", halt, 1'b0);
                checkValue("dWrite", dWrite, insn[29]);
                if (insn[29]) begin
                    checkValue("dAddr", dAddr, memAddr);
                    checkValue("dWriteData", dWriteData, storeData);
                    modelMem[memAddr[7:0]] = storeData;
                    stores++;
                    modelPc = modelPc + 1;
                end else begin
                    if (insn[27:24] != 4'd0 && insn[27:24] != 4'd15) begin
                        modelRegs[insn[27:24]] = result;
                    end
                    modelPc = (insn[27:24] == 4'd15) ? result : modelPc + 1;
                end
                executed++;
                nextCycle();
            end
        end
        $display("Test %0d finished after %0d instructions, %0d stores, %s, %0d errors",
                 testIndex, executed, stores, halted ? "halted" : "no halt", testErrors);
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before the tests completed");
        $display("Test failures found");
        $finish;
    end

    initial begin
        restart    = 1'b0;
        checkCount = 0;
        errorCount = 0;
        seedDummy  = $urandom(SEED);
        for (int t = 0; t < NUM_TESTS; t++) begin
            if (t > 0) begin
                restart = 1'b1;  // New reset and new memories
            end
            startTest();
            runProgram(t);
        end
        $display("%0d tests, %0d checks, %0d failed", NUM_TESTS, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
cpuPkg.sv
regFile.sv
insnDecoder.sv
aluExec.sv
cpuCore.sv
tbClock.sv
tbCpu.sv

// ==== Bender.yml ====
package:
  name: cpu_core

sources:
  - files:
      - cpuPkg.sv
      - regFile.sv
      - insnDecoder.sv
      - aluExec.sv
      - cpuCore.sv
  - target: test
    files:
      - tbClock.sv
      - tbCpu.sv
